/* neoIoSub.f */
neoBusPkg.sv
neoIoPkg.sv
neoAxiSlave.sv
neoPlayerPort.sv
neoSystemRegs.sv
neoIoTop.sv
neoIoTop_asserts.sv
tb_neoIoTop.sv

/* Bender.yml */
package:
  name: neoiosub

sources:
  - neoBusPkg.sv
  - neoIoPkg.sv
  - neoAxiSlave.sv
  - neoPlayerPort.sv
  - neoSystemRegs.sv
  - neoIoTop.sv
  - target: test
    files:
      - neoIoTop_asserts.sv
      - tb_neoIoTop.sv

/* neoIoTop_input.txt */
# Ops P: p1In p2In, D: dipSw, W: addr data resp, R: addr rdata resp
# O: playerOut coinCounter coinLockout slotSel; all hex, resp 0 okay and 2 slave error
# Reset state
O 00 0 0 01
# Player inputs, DIP switches and start/select
P 2a5 1c3
D a7
R 300000 00a5 0
R 340000 00c3 0
R 300001 00a7 0
R 380000 0006 0
R 31fffe 00a5 0
P 3ff 000
D 5c
R 380000 0003 0
R 300000 00ff 0
R 340000 0000 0
R 300001 005c 0
# Player outputs at the base and mirror addresses
W 380001 002b 0
O 2b 0 0 01
W 390001 0015 0
O 15 0 0 01
W 380081 ffff 0
O 3f 0 0 01
W 380041 0000 0
O 3f 0 0 01
# Slot latch
W 380021 0003 0
O 3f 0 0 08
W 380021 0005 0
O 3f 0 0 20
W 380021 0006 0
W 380021 000f 0
O 3f 0 0 20
W 380021 0000 0
O 3f 0 0 01
# Coin counters and lockouts
W 380071 0000 0
O 3f 1 0 01
W 380077 0000 0
O 3f 1 2 01
W 380073 0000 0
W 380075 0000 0
O 3f 3 3 01
W 380061 0000 0
O 3f 2 3 01
W 380067 0000 0
O 3f 2 1 01
# Outside the zone
W 3c0001 0000 2
W 300001 0007 2
W 380000 0000 2
W 780063 0000 2
O 3f 2 1 01
R 3c0000 0000 2
R 380001 0000 2
R 200000 0000 2
# Remaining clears
W 380063 0000 0
W 380065 0000 0
O 3f 0 0 01

/* tb_neoIoTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_neoIoTop
	import neoBusPkg::*, neoIoPkg::*;
();

	localparam int numPlayers = 2;
	localparam int syncStages = 2;
	localparam int resetCycles = 8;
	// Cycle budget per line of the stimulus file
	localparam int cyclesPerLine = 40;
	localparam string inputPath = "neoIoTop_input.txt";

	logic clk68k;
	logic rst;
	logic [axiAddrWidth-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axiDataWidth-1:0] wdata;
	logic [axiDataWidth/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [axiAddrWidth-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [axiDataWidth-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [numPlayers-1:0][inWidth-1:0] playerIn;
	logic [dipWidth-1:0] dipSw;
	logic [numPlayers-1:0][outWidth-1:0] playerOut;
	logic [numPlayers-1:0] coinCounter;
	logic [numPlayers-1:0] coinLockout;
	logic [slotWidth-1:0] slotSel;

	int errorCount;
	int checkCount;
	int cycleCount;
	int cycleLimit;
	logic [31:0] rndState;

	neoIoTop #(
		.numPlayers(numPlayers),
		.syncStages(syncStages)
	) i_neoIoTop (
		.clk68k(clk68k),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.playerIn(playerIn),
		.dipSw(dipSw),
		.playerOut(playerOut),
		.coinCounter(coinCounter),
		.coinLockout(coinLockout),
		.slotSel(slotSel)
	);

	// 4 ns period
	always #2 clk68k = ~clk68k;

	// Run limit from the file length
	always @(posedge clk68k)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("Timeout: the stimulus did not finish within %0d cycles", cycleLimit);
			$display("Summary: %0d checks, %0d errors", checkCount, errorCount + 1);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Ready three cycles out of four
	task automatic drawReady(output logic ready);
		rndState = xorshift(rndState);
		ready = (rndState[1:0] != 2'b00);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkFields(input int got, input int want, input logic [7:0] op);
		if (got != want)
		begin
			errorCount++;
			$display("Operation %c in the stimulus file has %0d fields, not %0d", op, got, want);
		end
	endtask

	task automatic runWrite(input logic [31:0] addr, input logic [31:0] data,
		input logic [31:0] expResp);
		logic ready;
		awaddr <= addr[axiAddrWidth-1:0];
		wdata <= {16'h0000, data[15:0]};
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do
			@(posedge clk68k);
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		drawReady(ready);
		bready <= ready;
		@(posedge clk68k);
		// Random stalls until the response is taken
		while (!(bvalid && bready))
		begin
			drawReady(ready);
			bready <= ready;
			@(posedge clk68k);
		end
		checkValue("bresp", bresp, expResp);
		bready <= 1'b0;
	endtask

	task automatic runRead(input logic [31:0] addr, input logic [31:0] expData,
		input logic [31:0] expResp);
		logic ready;
		araddr <= addr[axiAddrWidth-1:0];
		arvalid <= 1'b1;
		do
			@(posedge clk68k);
		while (!arready);
		arvalid <= 1'b0;
		drawReady(ready);
		rready <= ready;
		@(posedge clk68k);
		while (!(rvalid && rready))
		begin
			drawReady(ready);
			rready <= ready;
			@(posedge clk68k);
		end
		checkValue("rdata", rdata, expData);
		checkValue("rresp", rresp, expResp);
		rready <= 1'b0;
	endtask

	initial
	begin
		int fd;
		int code;
		int ch;
		int lineCount;
		int assertFails;
		logic [7:0] op;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		clk68k = 1'b0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		playerIn = '0;
		dipSw = '0;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		cycleLimit = 0;
		rndState = 32'h47fe_cd6a;
		// First pass counts lines for the run limit
		lineCount = 0;
		fd = $fopen(inputPath, "r");
		if (fd != 0)
		begin
			ch = $fgetc(fd);
			while (ch != -1)
			begin
				if (ch == "\n")
					lineCount++;
				ch = $fgetc(fd);
			end
			$fclose(fd);
		end
		cycleLimit = cyclesPerLine * lineCount + resetCycles;
		repeat (resetCycles) @(posedge clk68k);
		rst <= 1'b0;
		@(posedge clk68k);
		fd = $fopen(inputPath, "r");
		if (fd == 0)
		begin
			errorCount++;
			$display("Cannot open %s, no stimulus was applied", inputPath);
		end
		else
		begin
			code = $fscanf(fd, " %c", op);
			while (code == 1)
			begin
				case (op)
					"#":
					begin
						// Comment line, skip to its end
						ch = $fgetc(fd);
						while (ch != "\n" && ch != -1)
							ch = $fgetc(fd);
					end
					"P":
					begin
						code = $fscanf(fd, "%h %h", f0, f1);
						checkFields(code, 2, op);
						playerIn <= {f1[inWidth-1:0], f0[inWidth-1:0]};
						// Settle through the synchroniser
						repeat (8) @(posedge clk68k);
					end
					"D":
					begin
						code = $fscanf(fd, "%h", f0);
						checkFields(code, 1, op);
						dipSw <= f0[dipWidth-1:0];
						repeat (8) @(posedge clk68k);
					end
					"W":
					begin
						code = $fscanf(fd, "%h %h %h", f0, f1, f2);
						checkFields(code, 3, op);
						runWrite(f0, f1, f2);
					end
					"R":
					begin
						code = $fscanf(fd, "%h %h %h", f0, f1, f2);
						checkFields(code, 3, op);
						runRead(f0, f1, f2);
					end
					"O":
					begin
						code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
						checkFields(code, 4, op);
						checkValue("playerOut", playerOut, f0);
						checkValue("coinCounter", coinCounter, f1);
						checkValue("coinLockout", coinLockout, f2);
						checkValue("slotSel", slotSel, f3);
					end
					default:
					begin
						errorCount++;
						$display("Unknown operation %c in the stimulus file", op);
					end
				endcase
				code = $fscanf(fd, " %c", op);
			end
			$fclose(fd);
		end
		repeat (4) @(posedge clk68k);
		assertFails = i_neoIoTop.i_axiSlave.i_asserts.failCount;
		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* neoIoTop_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module neoIoTop_asserts
	import neoBusPkg::*;
(
	input wire clk68k,
	input wire rst,
	input wire awvalid,
	input wire awready,
	input wire wvalid,
	input wire wready,
	input wire arvalid,
	input wire arready,
	input wire [1:0] bresp,
	input wire bvalid,
	input wire bready,
	input wire [axiDataWidth-1:0] rdata,
	input wire [1:0] rresp,
	input wire rvalid,
	input wire rready
);

	// Number of failed assertions, summed into the testbench result
	int failCount = 0;

	// A stalled write response holds still
	bHeld: assert property (@(posedge clk68k) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else
	begin
		failCount++;
		$error("write response moved while stalled");
	end

	// A stalled read response holds still
	rHeld: assert property (@(posedge clk68k) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else
	begin
		failCount++;
		$error("read response moved while stalled");
	end

	// Write handshake at T, bvalid at T+2
	bLatency: assert property (@(posedge clk68k) disable iff (rst)
		awvalid && awready && wvalid && wready |=> !bvalid ##1 bvalid)
	else
	begin
		failCount++;
		$error("write response not two cycles after handshake");
	end

	// Read handshake at T, rvalid at T+2
	rLatency: assert property (@(posedge clk68k) disable iff (rst)
		arvalid && arready |=> !rvalid ##1 rvalid)
	else
	begin
		failCount++;
		$error("read response not two cycles after handshake");
	end

	// First cycle out of reset, idle with nothing offered
	resetLevels: assert property (@(posedge clk68k)
		$fell(rst) |-> arready && awready && wready && !bvalid && !rvalid)
	else
	begin
		failCount++;
		$error("ready or valid level wrong after reset");
	end

endmodule

bind neoAxiSlave neoIoTop_asserts i_asserts (
	.clk68k(clk68k),
	.rst(rst),
	.awvalid(awvalid),
	.awready(awready),
	.wvalid(wvalid),
	.wready(wready),
	.arvalid(arvalid),
	.arready(arready),
	.bresp(bresp),
	.bvalid(bvalid),
	.bready(bready),
	.rdata(rdata),
	.rresp(rresp),
	.rvalid(rvalid),
	.rready(rready)
);

`default_nettype wire

/* neoIoTop.sv */
`timescale 1ns/1ps
`default_nettype none

module neoIoTop
	import neoBusPkg::*, neoIoPkg::*;
#(
	parameter int numPlayers = 2,
	parameter int syncStages = 2
)
(
	input wire clk68k,
	input wire rst,
	input wire [axiAddrWidth-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [axiDataWidth-1:0] wdata,
	input wire [axiDataWidth/8-1:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [axiAddrWidth-1:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [axiDataWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,
	input wire [numPlayers-1:0][inWidth-1:0] playerIn,
	input wire [dipWidth-1:0] dipSw,
	output logic [numPlayers-1:0][outWidth-1:0] playerOut,
	output logic [numPlayers-1:0] coinCounter,
	output logic [numPlayers-1:0] coinLockout,
	output logic [slotWidth-1:0] slotSel
);

	logic wrStrobe;
	logic rdStrobe;
	neoLowAddr_u lowAddr;
	logic [wordWidth-1:0] wrData;
	logic [playerIdxWidth-1:0] portSel;
	logic [rdKindWidth-1:0] rdKind;
	logic [wordWidth-1:0] rdWord;
	logic [numPlayers-1:0][inWidth-1:0] syncIn;

	// Bus front end and zone decode
	neoAxiSlave i_axiSlave (
		.clk68k(clk68k),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.wrStrobe(wrStrobe),
		.rdStrobe(rdStrobe),
		.lowAddr(lowAddr),
		.wrData(wrData),
		.portSel(portSel),
		.rdKind(rdKind),
		.rdWord(rdWord)
	);

	// One port block per player
	for (genvar p = 0; p < numPlayers; p++)
	begin : gPort
		neoPlayerPort #(
			.syncStages(syncStages),
			.portIdx(p)
		) i_port (
			.clk68k(clk68k),
			.rst(rst),
			.playerIn(playerIn[p]),
			.wrStrobe(wrStrobe),
			.lowAddr(lowAddr),
			.wrData(wrData),
			.portSel(portSel),
			.syncIn(syncIn[p]),
			.playerOut(playerOut[p]),
			.coinCounter(coinCounter[p]),
			.coinLockout(coinLockout[p])
		);
	end

	// DIP, slot latch and read data back to the front end
	neoSystemRegs #(
		.numPlayers(numPlayers)
	) i_systemRegs (
		.clk68k(clk68k),
		.rst(rst),
		.dipSw(dipSw),
		.wrStrobe(wrStrobe),
		.rdStrobe(rdStrobe),
		.lowAddr(lowAddr),
		.wrData(wrData),
		.rdKind(rdKind),
		.portSel(portSel),
		.syncIn(syncIn),
		.slotSel(slotSel),
		.rdWord(rdWord)
	);

endmodule

`default_nettype wire

/* neoSystemRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module neoSystemRegs
	import neoBusPkg::*, neoIoPkg::*;
#(
	parameter int numPlayers = 2
)
(
	input wire clk68k,
	input wire rst,
	input wire [dipWidth-1:0] dipSw,
	input wire wrStrobe,
	input wire rdStrobe,
	input wire neoLowAddr_u lowAddr,
	input wire [wordWidth-1:0] wrData,
	input wire [rdKindWidth-1:0] rdKind,
	input wire [playerIdxWidth-1:0] portSel,
	input wire [numPlayers-1:0][inWidth-1:0] syncIn,
	output logic [slotWidth-1:0] slotSel,
	output logic [wordWidth-1:0] rdWord
);

	logic [dipWidth-1:0] dipSample;
	logic [slotNumWidth-1:0] slotNum;
	logic slotWrite;
	logic [wordWidth-1:0] pCntWord;
	logic [wordWidth-1:0] statBWord;
	logic [wordWidth-1:0] readMux;

	// DIP switches are slow, one register is enough
	always_ff @(posedge clk68k)
	begin
		dipSample <= dipSw;
	end

	// REG_SLOT, only slots 0 to 5 exist
	assign slotNum = wrData[slotNumWidth-1:0];
	assign slotWrite = wrStrobe & lowAddr.regView.odd
		& (lowAddr.regView.regSel == regSelSlot) & (slotNum < slotWidth);

	always_ff @(posedge clk68k)
	begin
		if (rst)
			slotSel <= slotWidth'(1);
		else if (slotWrite)
			slotSel <= slotWidth'(1) << slotNum;
	end

	// Read word assembly
	always_comb
	begin
		pCntWord = '0;
		statBWord = '0;
		for (int p = 0; p < numPlayers; p++)
		begin
			// Missing player reads as zero
			if (portSel == p)
				pCntWord[pCntWidth-1:0] = syncIn[p][pCntWidth-1:0];
			// Start and select from the top input bits
			statBWord[p*startSelWidth +: startSelWidth] = syncIn[p][inWidth-1 -: startSelWidth];
		end
		case (rdKind)
			rdKindPCnt:
				readMux = pCntWord;
			rdKindDip:
				readMux = {{(wordWidth-dipWidth){1'b0}}, dipSample};
			rdKindStatB:
				readMux = statBWord;
			default:
				readMux = '0;
		endcase
	end

	// Bus driven only while a read is strobed
	assign rdWord = rdStrobe ? readMux : '0;

endmodule

`default_nettype wire

/* neoPlayerPort.sv */
`timescale 1ns/1ps
`default_nettype none

module neoPlayerPort
	import neoBusPkg::*, neoIoPkg::*;
#(
	parameter int syncStages = 2,
	parameter int portIdx = 0
)
(
	input wire clk68k,
	input wire rst,
	input wire [inWidth-1:0] playerIn,
	input wire wrStrobe,
	input wire neoLowAddr_u lowAddr,
	input wire [wordWidth-1:0] wrData,
	input wire [playerIdxWidth-1:0] portSel,
	output logic [inWidth-1:0] syncIn,
	output logic [outWidth-1:0] playerOut,
	output logic coinCounter,
	output logic coinLockout
);

	localparam logic [playerIdxWidth-1:0] ownIdx = playerIdxWidth'(portIdx);

	logic [inWidth-1:0] syncChain [syncStages];
	logic outWrite;
	logic cntWrite;

	// Synchroniser for the raw joystick pins
	always_ff @(posedge clk68k)
	begin
		syncChain[0] <= playerIn;
		for (int i = 1; i < syncStages; i++)
			syncChain[i] <= syncChain[i-1];
		// One more stage toward the read mux
		syncIn <= syncChain[syncStages-1];
	end

	// REG_POUTPUT on the odd byte
	assign outWrite = wrStrobe & lowAddr.regView.odd
		& (lowAddr.regView.regSel == regSelPOutput);

	// NEO-I0 counter operation addressed to this player
	assign cntWrite = wrStrobe & lowAddr.cntView.odd
		& (lowAddr.cntView.cntPrefix == cntPrefixOp) & (portSel == ownIdx);

	always_ff @(posedge clk68k)
	begin
		if (rst)
		begin
			playerOut <= '0;
			coinCounter <= 1'b0;
			coinLockout <= 1'b0;
		end
		else
		begin
			// P1 takes bits 2:0, P2 bits 5:3
			if (outWrite)
				playerOut <= wrData[portIdx*outWidth +: outWidth];
			if (cntWrite)
			begin
				// A4 picks set or reset, A2 picks lockout or counter
				if (lowAddr.cntView.lockoutSel)
					coinLockout <= lowAddr.cntView.setNotReset;
				else
					coinCounter <= lowAddr.cntView.setNotReset;
			end
		end
	end

endmodule

`default_nettype wire

/* neoAxiSlave.sv */
`timescale 1ns/1ps
`default_nettype none

module neoAxiSlave
	import neoBusPkg::*, neoIoPkg::*;
(
	input wire clk68k,
	input wire rst,
	input wire [axiAddrWidth-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [axiDataWidth-1:0] wdata,
	input wire [axiDataWidth/8-1:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [axiAddrWidth-1:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [axiDataWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,
	output logic wrStrobe,
	output logic rdStrobe,
	output neoLowAddr_u lowAddr,
	output logic [wordWidth-1:0] wrData,
	output logic [playerIdxWidth-1:0] portSel,
	output logic [rdKindWidth-1:0] rdKind,
	input wire [wordWidth-1:0] rdWord
);

	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stStrobe = 2'd1;
	localparam logic [1:0] stResp = 2'd2;

	logic [1:0] state;
	logic isRead;
	logic inZone;
	logic idle;
	logic acceptRd;
	logic acceptWr;
	logic [axiAddrWidth-1:0] reqAddr;
	neoLowAddr_u reqLow;
	logic hitP1;
	logic hitDip;
	logic hitP2;
	logic hitStB;
	logic hitBitW;
	logic nextInZone;
	logic [rdKindWidth-1:0] nextKind;
	logic [playerIdxWidth-1:0] nextPort;

	// A23 and A22 low selects the I/O half, then A21..A17 pick the zone
	function automatic logic zoneMatch(input logic [axiAddrWidth-1:0] addr,
		input logic [axiAddrWidth-1:0] pattern);
		zoneMatch = (addr[axiAddrWidth-1 -: 2] == 2'b00) && ((addr & zoneMask) == pattern);
	endfunction

	assign idle = (state == stIdle);

	// Read wins when both arrive together
	assign acceptRd = idle & arvalid;
	assign acceptWr = idle & ~arvalid & awvalid & wvalid;

	// Readies are high when idle, AW and W only ever complete as a pair
	assign arready = idle;
	assign awready = idle & ~arvalid & (wvalid | ~awvalid);
	assign wready = idle & ~arvalid & (awvalid | ~wvalid);

	assign reqAddr = arvalid ? araddr : awaddr;
	assign reqLow = reqAddr[7:0];

	// Zone decode of the access being offered
	always_comb
	begin
		hitP1 = zoneMatch(reqAddr, zoneP1Cnt) & ~reqLow.regView.odd;
		hitDip = zoneMatch(reqAddr, zoneDipStat) & reqLow.regView.odd;
		hitP2 = zoneMatch(reqAddr, zoneP2Cnt) & ~reqLow.regView.odd;
		hitStB = zoneMatch(reqAddr, zoneStatusB) & ~reqLow.regView.odd;
		// Bit writes need the LDS lane
		hitBitW = zoneMatch(reqAddr, zoneBitW0) & reqLow.regView.odd & wstrb[0];
		if (arvalid)
		begin
			nextInZone = hitP1 | hitDip | hitP2 | hitStB;
			nextPort = playerIdxWidth'(hitP2);
			if (hitDip)
				nextKind = rdKindDip;
			else if (hitStB)
				nextKind = rdKindStatB;
			else if (hitP1 | hitP2)
				nextKind = rdKindPCnt;
			else
				nextKind = rdKindNone;
		end
		else
		begin
			nextInZone = hitBitW;
			nextKind = rdKindNone;
			// Counter operations name their player in A1
			nextPort = playerIdxWidth'(reqLow.cntView.playerSel);
		end
	end

	// Idle, strobe, respond
	always_ff @(posedge clk68k)
	begin
		if (rst)
		begin
			state <= stIdle;
			isRead <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (acceptRd | acceptWr)
					begin
						isRead <= arvalid;
						state <= stStrobe;
					end
				end
				stStrobe:
				begin
					bvalid <= ~isRead;
					rvalid <= isRead;
					state <= stResp;
				end
				default:
				begin
					// Held until the master takes it
					if ((bvalid & bready) | (rvalid & rready))
					begin
						bvalid <= 1'b0;
						rvalid <= 1'b0;
						state <= stIdle;
					end
				end
			endcase
		end
	end

	// Captured access and response payload
	always_ff @(posedge clk68k)
	begin
		if (acceptRd | acceptWr)
		begin
			inZone <= nextInZone;
			rdKind <= nextKind;
			portSel <= nextPort;
			lowAddr <= reqLow;
			wrData <= wdata[wordWidth-1:0];
		end
		if (state == stStrobe)
		begin
			bresp <= inZone ? respOkay : respSlvErr;
			rresp <= inZone ? respOkay : respSlvErr;
			rdata <= {{(axiDataWidth-wordWidth){1'b0}}, rdWord};
		end
	end

	// Out-of-zone accesses still respond but never strobe
	assign wrStrobe = (state == stStrobe) & ~isRead & inZone;
	assign rdStrobe = (state == stStrobe) & isRead & inZone;

endmodule

`default_nettype wire

/* neoIoPkg.sv */
`default_nettype none

package neoIoPkg;

	// Player inputs, 8 stick/button bits plus start and select
	localparam int inWidth = 10;
	// Low part of an input returned by REG_PxCNT
	localparam int pCntWidth = 8;
	// Start and select pair per player in REG_STATUS_B
	localparam int startSelWidth = 2;
	// REG_POUTPUT field per player
	localparam int outWidth = 3;
	localparam int dipWidth = 8;

	// One-hot slot output and its binary index
	localparam int slotWidth = 6;
	localparam int slotNumWidth = $clog2(slotWidth);

	// Player index carried with an access
	localparam int playerIdxWidth = 1;

	// Register selects on address bits 6:4 of nBITWD0
	localparam int regSelWidth = 3;
	localparam logic [regSelWidth-1:0] regSelPOutput = 3'd0;
	localparam logic [regSelWidth-1:0] regSelSlot = 3'd2;
	// Counter operations sit at selects 6 and 7
	localparam logic [1:0] cntPrefixOp = 2'b11;

	// Which read the front end has decoded
	localparam int rdKindWidth = 2;
	localparam logic [rdKindWidth-1:0] rdKindNone = 2'd0;
	localparam logic [rdKindWidth-1:0] rdKindPCnt = 2'd1;
	localparam logic [rdKindWidth-1:0] rdKindDip = 2'd2;
	localparam logic [rdKindWidth-1:0] rdKindStatB = 2'd3;

endpackage

`default_nettype wire

/* neoBusPkg.sv */
`default_nettype none

package neoBusPkg;

	// 68k byte address, A0 stands in for the LDS/UDS select
	localparam int axiAddrWidth = 24;
	localparam int axiDataWidth = 32;
	// Width of the 68k data bus carried in the low half of the AXI word
	localparam int wordWidth = 16;

	// AXI response codes
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// NEO-C1 style zone compare on A21..A17
	localparam logic [axiAddrWidth-1:0] zoneMask = 24'h3E0000;
	// REG_P1CNT on the even byte
	localparam logic [axiAddrWidth-1:0] zoneP1Cnt = 24'h300000;
	// REG_DIPSW shares the P1 zone on the odd byte (nDIPRD0)
	localparam logic [axiAddrWidth-1:0] zoneDipStat = 24'h300000;
	// REG_P2CNT on the even byte
	localparam logic [axiAddrWidth-1:0] zoneP2Cnt = 24'h340000;
	// REG_STATUS_B on the even byte
	localparam logic [axiAddrWidth-1:0] zoneStatusB = 24'h380000;
	// nBITW0 write zone on the odd byte
	localparam logic [axiAddrWidth-1:0] zoneBitW0 = 24'h380000;

	// Low address byte of an access
	// Read as a register select or as a NEO-I0 counter operation
	typedef union packed
	{
		struct packed
		{
			logic mirror;
			logic [2:0] regSel;
			logic [2:0] unused;
			logic odd;
		} regView;
		struct packed
		{
			logic mirror;
			// 11 marks a counter operation
			logic [1:0] cntPrefix;
			logic setNotReset;
			logic unused;
			logic lockoutSel;
			logic playerSel;
			logic odd;
		} cntView;
	} neoLowAddr_u;

endpackage

`default_nettype wire
